//--- logic/ctrl_consts.svh
// Controller width constants

`ifndef CTRL_CONSTS_SVH
`define CTRL_CONSTS_SVH

////////////////////
// control path
////////////////////

// program counter source select toward fetch
`define CTRL_PCMUX_W 3

// jump kind reported by the decoder
`define CTRL_JUMP_W 2

// main fsm state code
`define CTRL_STATE_W 3

////////////////////
// operand path
////////////////////

// per operand forwarding mux select
`define FWD_SEL_W 2

`endif

//--- logic/ctrl_pkg.sv
// Controller control types

`default_nettype none

`include "ctrl_consts.svh"

package ctrl_pkg;

  // fetch stage pc source
  typedef enum logic [`CTRL_PCMUX_W-1:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_src_e;

  // kind of control transfer sitting in decode
  typedef enum logic [`CTRL_JUMP_W-1:0] {
    NONE = 2'b00,
    JAL  = 2'b01,
    JALR = 2'b10,
    COND = 2'b11
  } jump_kind_e;

  // main fsm states
  typedef enum logic [`CTRL_STATE_W-1:0] {
    RESET,
    BOOT_SET,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH_EX,
    FLUSH_WB
  } ctrl_state_e;

  // decoder report for the instruction in id
  typedef struct packed {
    logic       illegal;
    logic       mret;
    logic       pipe_flush;
    jump_kind_e jump_in_dec;
  } dec_info_t;

  // exception controller strobes
  typedef struct packed {
    logic ack;
    logic irq_ack;
    logic save_if;
    logic save_id;
    logic save_branch;
    logic restore_mret;
  } exc_ctrl_t;

endpackage

`default_nettype wire

//--- logic/fwd_pkg.sv
// Operand forwarding types

`default_nettype none

`include "ctrl_consts.svh"

package fwd_pkg;

  // source of an id stage operand
  typedef enum logic [`FWD_SEL_W-1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fwd_sel_e;

  // destination register compares against sources a, b and c
  typedef struct packed {
    logic ex_a;
    logic ex_b;
    logic ex_c;
    logic wb_a;
    logic wb_b;
    logic wb_c;
    logic alu_a;
    logic alu_b;
    logic alu_c;
  } reg_match_t;

  // pending register file writes per stage
  typedef struct packed {
    logic we_ex;
    logic we_wb;
    logic alu_we_fw;
  } wb_en_t;

  // mux selects for the three id operands
  typedef struct packed {
    fwd_sel_e op_a;
    fwd_sel_e op_b;
    fwd_sel_e op_c;
  } fwd_sels_t;

endpackage

`default_nettype wire

//--- logic/ctrl_fsm.sv
// Main control FSM

`timescale 1ns/10ps
`default_nettype none

module ctrl_fsm (
  input  logic                clk,
  input  logic                rst_n,

  // core enable and id stage status
  input  logic                fetch_enable_i,
  input  logic                instr_valid_i,
  input  logic                id_ready_i,
  input  logic                ex_valid_i,

  // branch resolved in ex
  input  logic                branch_taken_ex_i,

  // decoder report
  input  ctrl_pkg::dec_info_t dec_info_i,

  // interrupt and exception requests
  input  logic                int_req_i,
  input  logic                ext_req_i,

  // hazard unit
  input  logic                jr_stall_i,

  output logic                ctrl_busy_o,
  output logic                is_decoding_o,
  output logic                instr_req_o,
  output logic                pc_set_o,
  output ctrl_pkg::pc_src_e   pc_mux_o,
  output ctrl_pkg::exc_ctrl_t exc_ctrl_o,
  output logic                halt_if_o,
  output logic                halt_id_o
);

  import ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // set once a jump or mret has redirected fetch
  logic jump_done_q;
  logic jump_done_d;

  logic exc_req;
  logic jump_uncond;

  assign exc_req     = int_req_i | ext_req_i;
  assign jump_uncond = (dec_info_i.jump_in_dec == JAL) || (dec_info_i.jump_in_dec == JALR);

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_d       = state_q;
    jump_done_d   = jump_done_q;

    instr_req_o   = 1'b1;
    ctrl_busy_o   = 1'b1;
    is_decoding_o = 1'b0;
    pc_set_o      = 1'b0;
    pc_mux_o      = PC_BOOT;
    exc_ctrl_o    = '0;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;

    case (state_q)
      // idle until the core is enabled
      RESET: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      // load boot address into fetch
      BOOT_SET: begin
        pc_mux_o = PC_BOOT;
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end

      // pipeline is empty, fetch stopped
      SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        // wake on enable or on any pending request
        if (fetch_enable_i || exc_req) begin
          state_d = FIRST_FETCH;
        end
      end

      // wait for the first instruction to land in id
      FIRST_FETCH: begin
        if (id_ready_i) begin
          state_d = DECODE;
        end
        // nothing in id yet so the if pc is saved
        if (exc_req) begin
          pc_mux_o           = PC_EXCEPTION;
          pc_set_o           = 1'b1;
          exc_ctrl_o.ack     = 1'b1;
          exc_ctrl_o.irq_ack = ext_req_i;
          exc_ctrl_o.save_if = 1'b1;
        end
      end

      DECODE: begin
        // a taken branch in ex kills the id instruction
        if (instr_valid_i && !branch_taken_ex_i) begin
          is_decoding_o = 1'b1;

          if (jump_uncond) begin
            // target is known in id, redirect once
            pc_mux_o = PC_JUMP;
            if (!jr_stall_i && !jump_done_q) begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end else if (int_req_i) begin
            // internal exception for the id instruction
            pc_mux_o           = PC_EXCEPTION;
            pc_set_o           = 1'b1;
            exc_ctrl_o.ack     = 1'b1;
            halt_id_o          = 1'b1;
            exc_ctrl_o.save_id = 1'b1;
          end

          if (dec_info_i.mret) begin
            // return to the saved epc
            pc_mux_o                = PC_ERET;
            exc_ctrl_o.restore_mret = 1'b1;
            if (!jump_done_q) begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end else if (ext_req_i) begin
            pc_mux_o           = PC_EXCEPTION;
            pc_set_o           = 1'b1;
            exc_ctrl_o.ack     = 1'b1;
            exc_ctrl_o.irq_ack = 1'b1;
            halt_id_o          = 1'b1;
            exc_ctrl_o.save_id = 1'b1;
          end

          // wfi style flush, or mret back into sleep
          if (dec_info_i.pipe_flush || (dec_info_i.mret && !fetch_enable_i)) begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end

        // empty id slot, external irq saves the if pc
        if (!instr_valid_i && !branch_taken_ex_i && ext_req_i) begin
          pc_mux_o           = PC_EXCEPTION;
          pc_set_o           = 1'b1;
          exc_ctrl_o.ack     = 1'b1;
          exc_ctrl_o.irq_ack = 1'b1;
          halt_id_o          = 1'b1;
          exc_ctrl_o.save_if = 1'b1;
        end

        if (branch_taken_ex_i) begin
          pc_mux_o = PC_BRANCH;
          pc_set_o = 1'b1;
          // irq outranks the branch target, save the target instead
          if (ext_req_i) begin
            pc_mux_o               = PC_EXCEPTION;
            exc_ctrl_o.ack         = 1'b1;
            exc_ctrl_o.irq_ack     = 1'b1;
            halt_id_o              = 1'b1;
            exc_ctrl_o.save_branch = 1'b1;
          end
        end
      end

      // drain ex stage
      FLUSH_EX: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i) begin
          state_d = FLUSH_WB;
        end
      end

      // drain wb stage, then resume or sleep
      FLUSH_WB: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i) begin
          halt_if_o = 1'b0;
          state_d   = DECODE;
        end else begin
          state_d = SLEEP;
        end
      end

      // unused code, recover
      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  ////////////////////
  // state registers
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // released once id accepts the next instruction
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/hazard_unit.sv
// Pipeline stall detection

`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
  input  logic                 is_decoding_i,
  input  logic                 illegal_i,
  input  ctrl_pkg::jump_kind_e jump_in_dec_i,
  input  logic                 data_req_ex_i,
  input  fwd_pkg::wb_en_t      wb_en_i,
  input  fwd_pkg::reg_match_t  reg_match_i,
  output logic                 load_stall_o,
  output logic                 jr_stall_o,
  output logic                 deassert_we_o
);

  import ctrl_pkg::*;

  logic ex_reads;
  logic a_pending;

  // id reads the register a load in ex is writing
  assign ex_reads = reg_match_i.ex_a | reg_match_i.ex_b | reg_match_i.ex_c;

  // source a still has a write in flight somewhere
  assign a_pending = (wb_en_i.we_ex     & reg_match_i.ex_a) |
                     (wb_en_i.we_wb     & reg_match_i.wb_a) |
                     (wb_en_i.alu_we_fw & reg_match_i.alu_a);

  ////////////////////
  // stalls
  ////////////////////

  // load data arrives too late to forward
  assign load_stall_o = data_req_ex_i & wb_en_i.we_ex & ex_reads;

  // jalr target is computed in id from rs1
  assign jr_stall_o = (jump_in_dec_i == JALR) & a_pending;

  ////////////////////
  // write enable kill
  ////////////////////

  // stalled, illegal or idle id must not commit
  assign deassert_we_o = load_stall_o | jr_stall_o | illegal_i | ~is_decoding_i;

endmodule

`default_nettype wire

//--- logic/fwd_unit.sv
// Operand forwarding select

`timescale 1ns/10ps
`default_nettype none

module fwd_unit (
  input  fwd_pkg::wb_en_t     wb_en_i,
  input  fwd_pkg::reg_match_t reg_match_i,
  input  logic                data_misaligned_i,
  input  logic                mult_multicycle_i,
  output fwd_pkg::fwd_sels_t  fwd_sels_o
);

  import fwd_pkg::*;

  // pick one operand source, alu path beats wb
  function automatic fwd_sel_e pick_src(input logic wb_hit, input logic alu_hit);
    fwd_sel_e sel;
    sel = SEL_REGFILE;
    if (wb_en_i.we_wb && wb_hit) begin
      sel = SEL_FW_WB;
    end
    if (wb_en_i.alu_we_fw && alu_hit) begin
      sel = SEL_FW_EX;
    end
    return sel;
  endfunction

  always_comb begin
    fwd_sels_o.op_a = pick_src(reg_match_i.wb_a, reg_match_i.alu_a);
    fwd_sels_o.op_b = pick_src(reg_match_i.wb_b, reg_match_i.alu_b);
    fwd_sels_o.op_c = pick_src(reg_match_i.wb_c, reg_match_i.alu_c);

    // second half of a misaligned access reuses the ex address
    if (data_misaligned_i) begin
      fwd_sels_o.op_a = SEL_FW_EX;
      fwd_sels_o.op_b = SEL_REGFILE;
    end else if (mult_multicycle_i) begin
      // multiplier keeps partial result on op c
      fwd_sels_o.op_c = SEL_FW_EX;
    end
  end

endmodule

`default_nettype wire

//--- logic/core_controller.sv
// Core controller top

`timescale 1ns/10ps
`default_nettype none

module core_controller (
  input  logic                clk,
  input  logic                rst_n,

  input  logic                fetch_enable_i,
  input  logic                instr_valid_i,
  input  logic                branch_taken_ex_i,
  input  ctrl_pkg::dec_info_t dec_info_i,
  input  logic                int_req_i,
  input  logic                ext_req_i,
  input  logic                id_ready_i,
  input  logic                ex_valid_i,

  // lsu and multiplier status
  input  logic                data_req_ex_i,
  input  logic                data_misaligned_i,
  input  logic                mult_multicycle_i,

  // register file hazard info
  input  fwd_pkg::wb_en_t     wb_en_i,
  input  fwd_pkg::reg_match_t reg_match_i,

  output logic                ctrl_busy_o,
  output logic                is_decoding_o,
  output logic                instr_req_o,
  output logic                pc_set_o,
  output ctrl_pkg::pc_src_e   pc_mux_o,
  output ctrl_pkg::exc_ctrl_t exc_ctrl_o,
  output logic                halt_if_o,
  output logic                halt_id_o,
  output logic                deassert_we_o,
  output logic                load_stall_o,
  output logic                jr_stall_o,
  output fwd_pkg::fwd_sels_t  fwd_sels_o
);

  ////////////////////
  // control fsm
  ////////////////////

  // jr stall holds back the jump, is_decoding gates we
  ctrl_fsm i_ctrl_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .dec_info_i        (dec_info_i),
    .int_req_i         (int_req_i),
    .ext_req_i         (ext_req_i),
    .jr_stall_i        (jr_stall_o),
    .ctrl_busy_o       (ctrl_busy_o),
    .is_decoding_o     (is_decoding_o),
    .instr_req_o       (instr_req_o),
    .pc_set_o          (pc_set_o),
    .pc_mux_o          (pc_mux_o),
    .exc_ctrl_o        (exc_ctrl_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o)
  );

  ////////////////////
  // stalls
  ////////////////////

  hazard_unit i_hazard_unit (
    .is_decoding_i (is_decoding_o),
    .illegal_i     (dec_info_i.illegal),
    .jump_in_dec_i (dec_info_i.jump_in_dec),
    .data_req_ex_i (data_req_ex_i),
    .wb_en_i       (wb_en_i),
    .reg_match_i   (reg_match_i),
    .load_stall_o  (load_stall_o),
    .jr_stall_o    (jr_stall_o),
    .deassert_we_o (deassert_we_o)
  );

  // forwarding sees only core inputs
  fwd_unit i_fwd_unit (
    .wb_en_i           (wb_en_i),
    .reg_match_i       (reg_match_i),
    .data_misaligned_i (data_misaligned_i),
    .mult_multicycle_i (mult_multicycle_i),
    .fwd_sels_o        (fwd_sels_o)
  );

endmodule

`default_nettype wire

//--- tests/tb_vectors.svh
// Controller test vectors

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// stim bits:  fetch_en instr_valid id_ready ex_valid | branch int_req ext_req data_req_ex
// expect bits: busy decoding instr_req pc_set | halt_if halt_id | deassert_we ld_stall jr_stall

localparam int NUM_ROWS = 25;

// decoder reports
localparam dec_info_t DEC_NONE  = '{1'b0, 1'b0, 1'b0, NONE};
localparam dec_info_t DEC_JAL   = '{1'b0, 1'b0, 1'b0, JAL};
localparam dec_info_t DEC_JALR  = '{1'b0, 1'b0, 1'b0, JALR};
localparam dec_info_t DEC_FLUSH = '{1'b0, 1'b0, 1'b1, NONE};

// write enables and register matches
localparam wb_en_t     WB_NONE = 3'b000;
localparam wb_en_t     WB_EX   = 3'b100;
localparam wb_en_t     WB_WB   = 3'b010;
localparam reg_match_t M_NONE  = 9'b000_000_000;
localparam reg_match_t M_EX_B  = 9'b010_000_000;
localparam reg_match_t M_WB_A  = 9'b000_100_000;

// exception strobes: ack irq_ack save_if save_id save_branch restore_mret
localparam exc_ctrl_t EXC_NONE    = 6'b000_000;
localparam exc_ctrl_t EXC_IRQ_BR  = 6'b110_010;
localparam exc_ctrl_t EXC_SAVE_IF = 6'b101_000;

row_t tab [NUM_ROWS];

task automatic fill_table();
  // reset, boot, first fetch, decode
  tab[0]  = {8'b0000_0000, DEC_NONE, WB_NONE, M_NONE, 9'b0000_00_100, PC_BOOT, EXC_NONE};
  tab[1]  = {8'b1000_0000, DEC_NONE, WB_NONE, M_NONE, 9'b0000_00_100, PC_BOOT, EXC_NONE};
  tab[2]  = {8'b1000_0000, DEC_NONE, WB_NONE, M_NONE, 9'b1011_00_100, PC_BOOT, EXC_NONE};
  tab[3]  = {8'b1110_0000, DEC_NONE, WB_NONE, M_NONE, 9'b1010_00_100, PC_BOOT, EXC_NONE};
  tab[4]  = {8'b1110_0000, DEC_NONE, WB_NONE, M_NONE, 9'b1110_00_000, PC_BOOT, EXC_NONE};
  tab[5]  = {8'b1010_0000, DEC_NONE, WB_NONE, M_NONE, 9'b1010_00_100, PC_BOOT, EXC_NONE};
  // load use, then jalr held until the wb write clears
  tab[6]  = {8'b1100_0001, DEC_NONE, WB_EX, M_EX_B, 9'b1110_00_110, PC_BOOT, EXC_NONE};
  tab[7]  = {8'b1100_0000, DEC_JALR, WB_WB, M_WB_A, 9'b1110_00_101, PC_BOOT, EXC_NONE};
  tab[8]  = {8'b1100_0000, DEC_JALR, WB_NONE, M_WB_A, 9'b1111_00_000, PC_JUMP, EXC_NONE};
  tab[9]  = {8'b1110_0000, DEC_JALR, WB_NONE, M_WB_A, 9'b1110_00_000, PC_JUMP, EXC_NONE};
  // jal redirects once per instruction
  tab[10] = {8'b1100_0000, DEC_JAL, WB_NONE, M_NONE, 9'b1111_00_000, PC_JUMP, EXC_NONE};
  tab[11] = {8'b1100_0000, DEC_JAL, WB_NONE, M_NONE, 9'b1110_00_000, PC_JUMP, EXC_NONE};
  tab[12] = {8'b1110_0000, DEC_JAL, WB_NONE, M_NONE, 9'b1110_00_000, PC_JUMP, EXC_NONE};
  tab[13] = {8'b1100_0000, DEC_JAL, WB_NONE, M_NONE, 9'b1111_00_000, PC_JUMP, EXC_NONE};
  tab[14] = {8'b1110_0000, DEC_NONE, WB_NONE, M_NONE, 9'b1110_00_000, PC_BOOT, EXC_NONE};
  // taken branch, then branch with external irq
  tab[15] = {8'b1110_1000, DEC_NONE, WB_NONE, M_NONE, 9'b1011_00_100, PC_BRANCH, EXC_NONE};
  tab[16] = {8'b1110_1010, DEC_NONE, WB_NONE, M_NONE, 9'b1011_01_100, PC_EXCEPTION, EXC_IRQ_BR};
  // flush into sleep, wake on internal request
  tab[17] = {8'b1110_0000, DEC_FLUSH, WB_NONE, M_NONE, 9'b1110_11_000, PC_BOOT, EXC_NONE};
  tab[18] = {8'b0000_0000, DEC_NONE, WB_NONE, M_NONE, 9'b1010_11_100, PC_BOOT, EXC_NONE};
  tab[19] = {8'b0001_0000, DEC_NONE, WB_NONE, M_NONE, 9'b1010_11_100, PC_BOOT, EXC_NONE};
  tab[20] = {8'b0000_0000, DEC_NONE, WB_NONE, M_NONE, 9'b1010_11_100, PC_BOOT, EXC_NONE};
  tab[21] = {8'b0000_0000, DEC_NONE, WB_NONE, M_NONE, 9'b0000_11_100, PC_BOOT, EXC_NONE};
  tab[22] = {8'b0000_0100, DEC_NONE, WB_NONE, M_NONE, 9'b0000_11_100, PC_BOOT, EXC_NONE};
  tab[23] = {8'b0000_0100, DEC_NONE, WB_NONE, M_NONE, 9'b1011_00_100, PC_EXCEPTION, EXC_SAVE_IF};
  tab[24] = {8'b1000_0000, DEC_NONE, WB_NONE, M_NONE, 9'b1010_00_100, PC_BOOT, EXC_NONE};
endtask

`endif

//--- tests/tb_core_controller.sv
// Core controller testbench

`timescale 1ns/10ps
`default_nettype none

module tb_core_controller;

  import ctrl_pkg::*;
  import fwd_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 5;
  localparam int RST_TIMEOUT = 20;
  localparam int RAND_ROUNDS = 200;

  // single bit inputs of one row
  typedef struct packed {
    logic fetch_enable, instr_valid, id_ready, ex_valid;
    logic branch_taken, int_req, ext_req, data_req_ex;
  } stim_flags_t;

  typedef struct packed {
    stim_flags_t flags;
    dec_info_t   dec;
    wb_en_t      wb_en;
    reg_match_t  match;
  } stim_t;

  // single bit outputs of one row
  typedef struct packed {
    logic busy, decoding, instr_req, pc_set;
    logic halt_if, halt_id;
    logic deassert_we, load_stall, jr_stall;
  } exp_flags_t;

  typedef struct packed {
    exp_flags_t flags;
    pc_src_e    pc_mux;
    exc_ctrl_t  exc;
  } expect_t;

  typedef struct packed {
    stim_t   stim;
    expect_t expv;
  } row_t;

  logic       clk;
  logic       rst_n;
  logic       fetch_enable_i;
  logic       instr_valid_i;
  logic       branch_taken_ex_i;
  dec_info_t  dec_info_i;
  logic       int_req_i;
  logic       ext_req_i;
  logic       id_ready_i;
  logic       ex_valid_i;
  logic       data_req_ex_i;
  logic       data_misaligned_i;
  logic       mult_multicycle_i;
  wb_en_t     wb_en_i;
  reg_match_t reg_match_i;
  logic       ctrl_busy_o;
  logic       is_decoding_o;
  logic       instr_req_o;
  logic       pc_set_o;
  pc_src_e    pc_mux_o;
  exc_ctrl_t  exc_ctrl_o;
  logic       halt_if_o;
  logic       halt_id_o;
  logic       deassert_we_o;
  logic       load_stall_o;
  logic       jr_stall_o;
  fwd_sels_t  fwd_sels_o;

  `include "tb_vectors.svh"

  core_controller i_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .dec_info_i        (dec_info_i),
    .int_req_i         (int_req_i),
    .ext_req_i         (ext_req_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .data_req_ex_i     (data_req_ex_i),
    .data_misaligned_i (data_misaligned_i),
    .mult_multicycle_i (mult_multicycle_i),
    .wb_en_i           (wb_en_i),
    .reg_match_i       (reg_match_i),
    .ctrl_busy_o       (ctrl_busy_o),
    .is_decoding_o     (is_decoding_o),
    .instr_req_o       (instr_req_o),
    .pc_set_o          (pc_set_o),
    .pc_mux_o          (pc_mux_o),
    .exc_ctrl_o        (exc_ctrl_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o),
    .deassert_we_o     (deassert_we_o),
    .load_stall_o      (load_stall_o),
    .jr_stall_o        (jr_stall_o),
    .fwd_sels_o        (fwd_sels_o)
  );

  ////////////////////
  // clock and reset
  ////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst_n <= 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

  ////////////////////
  // reference model
  ////////////////////

  // alu path outranks wb which outranks the register file
  function automatic fwd_sel_e rank_src(input logic wb_fwd, input logic alu_fwd);
    fwd_sel_e sel;
    if (alu_fwd) begin
      sel = SEL_FW_EX;
    end else if (wb_fwd) begin
      sel = SEL_FW_WB;
    end else begin
      sel = SEL_REGFILE;
    end
    return sel;
  endfunction

  function automatic fwd_sels_t predict_fwd(input wb_en_t we, input reg_match_t m,
                                            input logic mis, input logic mult);
    fwd_sels_t s;
    s.op_a = rank_src(we.we_wb & m.wb_a, we.alu_we_fw & m.alu_a);
    s.op_b = rank_src(we.we_wb & m.wb_b, we.alu_we_fw & m.alu_b);
    s.op_c = rank_src(we.we_wb & m.wb_c, we.alu_we_fw & m.alu_c);
    // misaligned second access beats the multiplier override
    if (mis) begin
      s.op_a = SEL_FW_EX;
      s.op_b = SEL_REGFILE;
    end else if (mult) begin
      s.op_c = SEL_FW_EX;
    end
    return s;
  endfunction

  ////////////////////
  // helpers
  ////////////////////

  task automatic report_mismatch(input string name, input int step,
                                 input logic [31:0] got, input logic [31:0] want);
    $display("mismatch %s at step %0d: got 0x%0h, expected 0x%0h", name, step, got, want);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic expect_equal(input string name, input int step,
                              input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else report_mismatch(name, step, got, want);
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      cycles++;
      if (cycles > RST_TIMEOUT) begin
        $display("timeout: reset was never released");
        $display("TEST FAILED");
        $fatal(1, "reset wait timed out");
      end
    end
  endtask

  // drive one row right after the rising edge
  task automatic apply_stim(input stim_t s);
    fetch_enable_i    <= s.flags.fetch_enable;
    instr_valid_i     <= s.flags.instr_valid;
    id_ready_i        <= s.flags.id_ready;
    ex_valid_i        <= s.flags.ex_valid;
    branch_taken_ex_i <= s.flags.branch_taken;
    int_req_i         <= s.flags.int_req;
    ext_req_i         <= s.flags.ext_req;
    data_req_ex_i     <= s.flags.data_req_ex;
    dec_info_i        <= s.dec;
    wb_en_i           <= s.wb_en;
    reg_match_i       <= s.match;
    data_misaligned_i <= 1'b0;
    mult_multicycle_i <= 1'b0;
  endtask

  task automatic compare_outputs(input int step, input expect_t e);
    fwd_sels_t f;
    f = predict_fwd(wb_en_i, reg_match_i, data_misaligned_i, mult_multicycle_i);
    expect_equal("ctrl_busy_o", step, 32'(ctrl_busy_o), 32'(e.flags.busy));
    expect_equal("is_decoding_o", step, 32'(is_decoding_o), 32'(e.flags.decoding));
    expect_equal("instr_req_o", step, 32'(instr_req_o), 32'(e.flags.instr_req));
    expect_equal("pc_set_o", step, 32'(pc_set_o), 32'(e.flags.pc_set));
    expect_equal("halt_if_o", step, 32'(halt_if_o), 32'(e.flags.halt_if));
    expect_equal("halt_id_o", step, 32'(halt_id_o), 32'(e.flags.halt_id));
    expect_equal("deassert_we_o", step, 32'(deassert_we_o), 32'(e.flags.deassert_we));
    expect_equal("load_stall_o", step, 32'(load_stall_o), 32'(e.flags.load_stall));
    expect_equal("jr_stall_o", step, 32'(jr_stall_o), 32'(e.flags.jr_stall));
    expect_equal("exc_ctrl_o", step, 32'(exc_ctrl_o), 32'(e.exc));
    // pc source only matters while pc_set is high
    if (e.flags.pc_set) begin
      expect_equal("pc_mux_o", step, 32'(pc_mux_o), 32'(e.pc_mux));
    end
    expect_equal("fwd_sels_o", step, 32'(fwd_sels_o), 32'(f));
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    integer      seed;
    logic [31:0] rnd;
    fetch_enable_i    <= 1'b0;
    instr_valid_i     <= 1'b0;
    branch_taken_ex_i <= 1'b0;
    dec_info_i        <= '0;
    int_req_i         <= 1'b0;
    ext_req_i         <= 1'b0;
    id_ready_i        <= 1'b0;
    ex_valid_i        <= 1'b0;
    data_req_ex_i     <= 1'b0;
    data_misaligned_i <= 1'b0;
    mult_multicycle_i <= 1'b0;
    wb_en_i           <= '0;
    reg_match_i       <= '0;
    seed              = 32'hdefb;

    wait_reset_release();
    fill_table();

    // directed rows checked late in the cycle
    for (int i = 0; i < NUM_ROWS; i++) begin
      @(posedge clk);
      apply_stim(tab[i].stim);
      #(CLK_PERIOD - 5);
      compare_outputs(i, tab[i].expv);
    end

    // random match and enable patterns through the forwarding mux
    for (int k = 0; k < RAND_ROUNDS; k++) begin
      @(posedge clk);
      rnd = $random(seed);
      wb_en_i           <= rnd[2:0];
      reg_match_i       <= rnd[11:3];
      data_misaligned_i <= rnd[12] & rnd[13];
      mult_multicycle_i <= rnd[14];
      #(CLK_PERIOD - 5);
      expect_equal("fwd_sels_o", NUM_ROWS + k, 32'(fwd_sels_o),
                   32'(predict_fwd(wb_en_i, reg_match_i,
                                   data_misaligned_i, mult_multicycle_i)));
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- core_controller.f
+incdir+logic
+incdir+tests
logic/ctrl_pkg.sv
logic/fwd_pkg.sv
logic/ctrl_fsm.sv
logic/hazard_unit.sv
logic/fwd_unit.sv
logic/core_controller.sv
tests/tb_core_controller.sv

//--- run.sh
#!/bin/sh
# build the core controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f core_controller.f --top-module tb_core_controller \
  --Mdir obj_dir -o tb_core_controller
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_core_controller
status=$?
if [ $status -ne 0 ]; then
  echo "simulation ended with status $status"
  exit $status
fi

echo "simulation ended cleanly"
exit 0
